// File: reg_board.f
src/reg_board_pkg.sv
src/field_decoder.sv
src/major_register.sv
src/panel_mux.sv
src/reg_board.sv
bench/reg_board_checker.sv
bench/reg_board_tb.sv

// File: Makefile
# Verilator build and run for the register board testbench

SRCS := $(filter-out +%,$(shell cat reg_board.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vreg_board_tb: reg_board.f $(SRCS)
	verilator --binary --timing --top-module reg_board_tb -f reg_board.f

sim.log: obj_dir/Vreg_board_tb bench/reg_board_stimulus.txt
	./obj_dir/Vreg_board_tb > sim.log || true
	cat sim.log

run: sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/reg_board_stimulus.txt
// Inputs: raddr waddr action ibus_in panel_sel (register * 2 + high byte), all hex
// Expected before the edge that ends the line: ibus_out ibus_drive fpd ac_out fz pc_hi
// After reset, reads of every register
08 00 00 0000 0   0000 1 00 0000 1 00
09 00 00 0000 3   0000 1 00 0000 1 00
0A 00 00 0000 5   0000 1 00 0000 1 00
0B 00 00 0000 6   0000 1 00 0000 1 00
0C 00 00 0000 7   0000 0 00 0000 1 00
// Writes, read-backs and dead addresses
00 08 00 C3A5 0   0000 0 00 0000 1 00
08 09 00 5A17 1   C3A5 1 C3 0000 1 30
09 0A 00 8001 2   5A17 1 17 0000 1 30
0A 0B 00 1234 5   8001 1 80 8001 0 30
0B 00 00 FFFF 6   1234 1 34 8001 0 30
0C 00 00 0000 7   0000 0 12 8001 0 30
0F 00 00 0000 0   0000 0 A5 8001 0 30
18 00 00 0000 3   0000 0 5A 8001 0 30
1B 00 00 0000 4   0000 0 01 8001 0 30
07 00 00 0000 2   0000 0 17 8001 0 30
00 19 00 FFFF 2   0000 0 17 8001 0 30
09 00 00 0000 0   5A17 1 A5 8001 0 30
// Actions with wrap
00 08 00 FFFF 0   0000 0 A5 8001 0 30
08 00 08 0000 1   FFFF 1 FF 8001 0 3F
08 00 00 0000 0   0000 1 00 8001 0 00
09 00 0A 0000 2   5A17 1 17 8001 0 00
09 00 0B 0000 2   5A18 1 18 8001 0 00
09 00 0B 0000 3   5A17 1 5A 8001 0 00
09 00 00 0000 2   5A16 1 16 8001 0 00
0A 00 0D 0000 4   8001 1 01 8001 0 00
0A 0A 00 0001 4   8000 1 00 8000 0 00
0A 00 0D 0000 4   0001 1 01 0001 0 00
0A 00 0D 0000 5   0000 1 00 0000 1 00
0A 00 0C 0000 5   FFFF 1 FF FFFF 0 00
0A 00 00 0000 4   0000 1 00 0000 1 00
0B 00 0E 0000 6   1234 1 34 0000 1 00
0B 00 0F 0000 6   1235 1 35 0000 1 00
0B 0B 00 0000 7   1234 1 12 0000 1 00
0B 00 0F 0000 7   0000 1 00 0000 1 00
0B 00 0E 0000 7   FFFF 1 FF 0000 1 00
// Codes that change nothing
0B 00 09 0000 6   0000 1 00 0000 1 00
0B 00 05 0000 6   0000 1 00 0000 1 00
0A 00 1C 0000 4   0000 1 00 0000 1 00
09 00 07 0000 2   5A16 1 16 0000 1 00
08 00 00 0000 0   0000 1 00 0000 1 00
// Write and action in the same cycle
00 0A 0C 4000 4   0000 0 00 0000 1 00
0A 09 0B 00FF 5   4000 1 40 4000 0 00
09 08 0E 7C00 2   00FF 1 FF 4000 0 00
0B 00 00 0000 1   0001 1 7C 4000 0 1F
08 0B 0D ABCD 6   7C00 1 01 4000 0 1F
0A 00 00 0000 7   3FFF 1 AB 3FFF 0 1F
// Read and write of one register, then every panel select
0B 0B 00 0F3C 6   ABCD 1 CD 3FFF 0 1F
0B 00 00 0000 6   0F3C 1 3C 3FFF 0 1F
08 00 08 0000 0   7C00 1 00 3FFF 0 1F
00 00 00 0000 0   0000 0 01 3FFF 0 1F
00 00 00 0000 1   0000 0 7C 3FFF 0 1F
00 00 00 0000 2   0000 0 FF 3FFF 0 1F
00 00 00 0000 3   0000 0 00 3FFF 0 1F
00 00 00 0000 4   0000 0 FF 3FFF 0 1F
00 00 00 0000 5   0000 0 3F 3FFF 0 1F
00 00 00 0000 6   0000 0 3C 3FFF 0 1F
00 00 00 0000 7   0000 0 0F 3FFF 0 1F
0A 0A 00 0000 4   3FFF 1 FF 3FFF 0 1F
0A 00 00 0000 5   0000 1 00 0000 1 1F

// File: bench/reg_board_tb.sv
// Testbench top for the register board; replays the stimulus file and lets the checker judge
`timescale 1ns/1ps

module reg_board_tb
   import reg_board_pkg::*;
();

   localparam int NUM_COLS      = 11;     // Words per stimulus line
   localparam int MEM_WORDS     = 1024;   // Room for about 90 lines
   localparam int RESET_CYCLES  = 16;
   localparam int RUN_TIMEOUT   = 90;     // Cycles allowed to reach the end marker
   localparam int DRAIN_TIMEOUT = 10;     // Cycles allowed for the last compare

   logic                   clk4 = 1'b0;
   logic                   reset;
   field_t                 raddr;
   field_t                 waddr;
   field_t                 action;
   word_t                  ibus_in;
   panel_sel_t             panel_sel;
   word_t                  ibus_out;
   logic                   ibus_drive;
   logic [BYTE_BITS-1:0]   fpd;
   word_t                  ac_out;
   logic                   fz;
   logic [PC_OUT_BITS-1:0] pc_hi;

   // Expected values of the line on the inputs
   logic                   check_en;
   int                     test_num;
   word_t                  exp_ibus_out;
   logic                   exp_ibus_drive;
   logic [BYTE_BITS-1:0]   exp_fpd;
   word_t                  exp_ac_out;
   logic                   exp_fz;
   logic [PC_OUT_BITS-1:0] exp_pc_hi;

   int                     tests_done;
   int                     tests_failed;
   int                     mismatches;

   logic [15:0]            stim_mem [0:MEM_WORDS-1];   // Whole file, line after line
   logic [9:0]             row;                        // First word of the current line
   int                     num_tests;
   int                     wait_cycles;
   logic                   timed_out;

   always #50 clk4 = ~clk4;                             // 100 ns period

   //////////////////////////////
   // DUT and checker
   //////////////////////////////

   reg_board i_dut (
      .clk4       (clk4),
      .reset      (reset),
      .raddr      (raddr),
      .waddr      (waddr),
      .action     (action),
      .ibus_in    (ibus_in),
      .ibus_out   (ibus_out),
      .ibus_drive (ibus_drive),
      .panel_sel  (panel_sel),
      .fpd        (fpd),
      .ac_out     (ac_out),
      .fz         (fz),
      .pc_hi      (pc_hi)
   );

   reg_board_checker i_checker (
      .clk4           (clk4),
      .check_en       (check_en),
      .test_num       (test_num),
      .ibus_out       (ibus_out),
      .ibus_drive     (ibus_drive),
      .fpd            (fpd),
      .ac_out         (ac_out),
      .fz             (fz),
      .pc_hi          (pc_hi),
      .exp_ibus_out   (exp_ibus_out),
      .exp_ibus_drive (exp_ibus_drive),
      .exp_fpd        (exp_fpd),
      .exp_ac_out     (exp_ac_out),
      .exp_fz         (exp_fz),
      .exp_pc_hi      (exp_pc_hi),
      .tests_done     (tests_done),
      .tests_failed   (tests_failed),
      .mismatches     (mismatches)
   );

   // Inputs from columns 0 to 4, expected outputs from columns 5 to 10
   task automatic apply_line(input logic [9:0] base);
      raddr          = stim_mem[base][NUM_FIELD_BITS-1:0];
      waddr          = stim_mem[base + 10'd1][NUM_FIELD_BITS-1:0];
      action         = stim_mem[base + 10'd2][NUM_FIELD_BITS-1:0];
      ibus_in        = stim_mem[base + 10'd3];
      panel_sel      = panel_sel_t'(stim_mem[base + 10'd4][2:0]);
      exp_ibus_out   = stim_mem[base + 10'd5];
      exp_ibus_drive = stim_mem[base + 10'd6][0];
      exp_fpd        = stim_mem[base + 10'd7][BYTE_BITS-1:0];
      exp_ac_out     = stim_mem[base + 10'd8];
      exp_fz         = stim_mem[base + 10'd9][0];
      exp_pc_hi      = stim_mem[base + 10'd10][PC_OUT_BITS-1:0];
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin
      reset     = 1'b1;
      raddr     = '0;                                   // Bit 3 low keeps every field idle
      waddr     = '0;
      action    = '0;
      ibus_in   = '0;
      panel_sel = '0;
      check_en  = 1'b0;
      test_num  = 0;
      num_tests = 0;
      timed_out = 1'b0;

      // Anything past the file ends up above 0x1F in the raddr column
      for (int i = 0; i < MEM_WORDS; i++) begin
         stim_mem[i[9:0]] = 16'hF000 | 16'(i);
      end
      $readmemh("bench/reg_board_stimulus.txt", stim_mem);

      repeat (RESET_CYCLES) @(posedge clk4);
      #1;
      reset = 1'b0;

      // One line per cycle until the end marker
      row         = '0;
      wait_cycles = 0;
      while (stim_mem[row] <= 16'h001F && wait_cycles < RUN_TIMEOUT) begin
         @(posedge clk4);
         #1;
         apply_line(row);
         test_num  = num_tests;
         check_en  = 1'b1;
         num_tests = num_tests + 1;
         row       = row + 10'(NUM_COLS);
         wait_cycles++;
      end
      if (stim_mem[row] <= 16'h001F) begin
         $display("Timeout: the stimulus file did not end within %0d cycles", RUN_TIMEOUT);
         timed_out = 1'b1;
      end

      @(posedge clk4);
      #1;
      check_en = 1'b0;
      raddr    = '0;
      waddr    = '0;
      action   = '0;

      // Last line is compared at the falling edge before this point
      wait_cycles = 0;
      while (tests_done < num_tests && wait_cycles < DRAIN_TIMEOUT) begin
         @(posedge clk4);
         wait_cycles++;
      end
      if (tests_done < num_tests) begin
         $display("Timeout: the checker compared %0d of %0d lines", tests_done, num_tests);
         timed_out = 1'b1;
      end

      i_checker.report_counts();
      if (!timed_out && num_tests > 0 && tests_failed == 0 && mismatches == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: bench/reg_board_checker.sv
// Testbench monitor that compares the register board outputs with each test's expected values
`timescale 1ns/1ps

module reg_board_checker
   import reg_board_pkg::*;
(
   input  logic                   clk4,           // Board clock
   input  logic                   check_en,       // A test line sits on the DUT inputs
   input  int                     test_num,       // Line number in the stimulus file

   // Outputs of the DUT
   input  word_t                  ibus_out,
   input  logic                   ibus_drive,
   input  logic [BYTE_BITS-1:0]   fpd,
   input  word_t                  ac_out,
   input  logic                   fz,
   input  logic [PC_OUT_BITS-1:0] pc_hi,

   // Expected values from the stimulus file
   input  word_t                  exp_ibus_out,
   input  logic                   exp_ibus_drive,
   input  logic [BYTE_BITS-1:0]   exp_fpd,
   input  word_t                  exp_ac_out,
   input  logic                   exp_fz,
   input  logic [PC_OUT_BITS-1:0] exp_pc_hi,

   output int                     tests_done,     // Lines compared so far
   output int                     tests_failed,   // Lines with at least one mismatch
   output int                     mismatches      // Single wrong signals
);

   int done_cnt = 0;
   int fail_cnt = 0;
   int err_cnt  = 0;

   assign tests_done   = done_cnt;
   assign tests_failed = fail_cnt;
   assign mismatches   = err_cnt;

   // One signal against its expected value, widened to a word for the message
   task automatic compare(input string name, input word_t expected, input word_t actual,
                          inout int line_errs);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: test %0d %s expected %h got %h",
                  $time, test_num, name, expected, actual);
         line_errs++;                                     // Counted per line and overall
         err_cnt++;
      end
   endtask

   //////////////////////////////
   // Compare in mid cycle
   //////////////////////////////

   // Inputs change 1 ns after the rising edge, so the falling edge sees settled outputs
   always @(negedge clk4) begin
      int line_errs;
      line_errs = 0;
      if (check_en) begin
         compare("ibus_out",   exp_ibus_out,           ibus_out,           line_errs);
         compare("ibus_drive", word_t'(exp_ibus_drive), word_t'(ibus_drive), line_errs);
         compare("fpd",        word_t'(exp_fpd),        word_t'(fpd),        line_errs);
         compare("ac_out",     exp_ac_out,             ac_out,             line_errs);
         compare("fz",         word_t'(exp_fz),         word_t'(fz),         line_errs);
         compare("pc_hi",      word_t'(exp_pc_hi),      word_t'(pc_hi),      line_errs);
         if (line_errs == 0) begin
            $display("test %0d passed", test_num);
         end else begin
            $display("test %0d failed with %0d wrong signals", test_num, line_errs);
            fail_cnt++;
         end
         done_cnt++;
      end
   end

   //////////////////////////////
   // Closing counts
   //////////////////////////////

   task automatic report_counts();
      $display("tests run %0d, passed %0d, failed %0d, wrong signals %0d",
               done_cnt, done_cnt - fail_cnt, fail_cnt, err_cnt);
   endtask

endmodule

// File: src/reg_board.sv
// Register board top with PC, DR, AC and SP behind the microcode decoders, bus merge and panel port
`timescale 1ns/1ps

module reg_board
   import reg_board_pkg::*;
(
   input  logic                   clk4,         // Write phase clock
   input  logic                   reset,        // Synchronous, active high

   // Microcode fields
   input  field_t                 raddr,        // Bus read address
   input  field_t                 waddr,        // Bus write address
   input  field_t                 action,       // Inc and dec actions

   // Processor bus split in two directions
   input  word_t                  ibus_in,      // Bus value from the other boards
   output word_t                  ibus_out,     // Bus value from this board
   output logic                   ibus_drive,   // This board owns the bus

   // Front panel
   input  panel_sel_t             panel_sel,    // Register and byte half
   output logic [BYTE_BITS-1:0]   fpd,          // Selected byte

   // Unbussed outputs to neighbouring boards
   output word_t                  ac_out,       // Full accumulator
   output logic                   fz,           // Accumulator is zero
   output logic [PC_OUT_BITS-1:0] pc_hi         // PC bits 15:10
);

   //////////////////////////////
   // Local signals
   //////////////////////////////

   board_ctl_t            ctl;         // Decoded control, one per register
   word_t  [NUM_REGS-1:0] values;      // Register contents
   logic   [NUM_REGS-1:0] zero_flags;  // Per register zero flag

   //////////////////////////////
   // Decoders
   //////////////////////////////

   field_decoder i_decoder (
      .raddr  (raddr),
      .waddr  (waddr),
      .action (action),
      .ctl    (ctl)
   );

   //////////////////////////////
   // Major registers
   //////////////////////////////

   // Same block four times, the PC never sees a dec code
   for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
      major_register i_reg (
         .clk4    (clk4),
         .reset   (reset),
         .ctl     (ctl[i]),
         .ibus_in (ibus_in),
         .value   (values[i]),
         .zero    (zero_flags[i])
      );
   end

   //////////////////////////////
   // Bus merge
   //////////////////////////////

   // Read bits are one-hot so an OR of the gated words is the mux
   always_comb begin
      ibus_out   = '0;                         // Idle bus reads zero
      ibus_drive = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
         if (ctl[i].read) begin
            ibus_out   = ibus_out | values[i];
            ibus_drive = 1'b1;                 // Tri-state enable stand-in
         end
      end
   end

   //////////////////////////////
   // Front panel and side outputs
   //////////////////////////////

   panel_mux i_panel (
      .values    (values),
      .panel_sel (panel_sel),
      .fpd       (fpd)
   );

   assign ac_out = values[REG_AC];                              // Accumulator to the ALU side
   assign fz     = zero_flags[REG_AC];                          // Zero flag of the AC only
   assign pc_hi  = values[REG_PC][WORD_BITS-1 -: PC_OUT_BITS];  // Top of the PC for paging

endmodule

// File: src/panel_mux.sv
// Front panel byte selector that shows one half of one major register on the shared port
`timescale 1ns/1ps

module panel_mux
   import reg_board_pkg::*;
(
   input  word_t [NUM_REGS-1:0] values,     // All four register values
   input  panel_sel_t           panel_sel,  // Register and byte half
   output logic [BYTE_BITS-1:0] fpd         // Front panel data
);

   word_t sel_word;                         // Chosen register

   //////////////////////////////
   // Register then byte
   //////////////////////////////

   assign sel_word = values[panel_sel.sel_reg];

   always_comb begin
      if (panel_sel.hi_byte) begin
         fpd = sel_word[WORD_BITS-1 -: BYTE_BITS];   // Bits 15:8
      end else begin
         fpd = sel_word[BYTE_BITS-1:0];              // Bits 7:0
      end
   end

endmodule

// File: src/major_register.sv
// One 16-bit major register of the board with load, increment, decrement and a zero flag
`timescale 1ns/1ps

module major_register
   import reg_board_pkg::*;
(
   input  logic     clk4,      // Write phase clock
   input  logic     reset,     // Synchronous, active high
   input  reg_ctl_t ctl,       // Decoded control for this register
   input  word_t    ibus_in,   // Processor bus towards the board
   output word_t    value,     // Held word
   output logic     zero       // Held word is zero
);

   //////////////////////////////
   // Storage
   //////////////////////////////

   word_t value_q;              // The register itself
   word_t value_d;              // Next value
   logic  upd;                  // Some operation lands this cycle

   // Write beats inc, inc beats dec
   always_comb begin
      value_d = value_q;                  // Hold by default
      if (ctl.write) begin
         value_d = ibus_in;               // Load from the bus
      end else if (ctl.inc) begin
         value_d = value_q + word_t'(1);  // Wraps at 0xFFFF
      end else if (ctl.dec) begin
         value_d = value_q - word_t'(1);  // Wraps at 0x0000
      end
   end

   assign upd = ctl.write | ctl.inc | ctl.dec;

   always_ff @(posedge clk4) begin
      if (reset) begin
         value_q <= '0;                   // Board comes up cleared
      end else if (upd) begin
         value_q <= value_d;              // One cycle latency
      end
   end

   //////////////////////////////
   // Outputs
   //////////////////////////////

   assign value = value_q;                // Old value while a write is pending
   assign zero  = (value_q == '0);        // Straight from the held word

endmodule

// File: src/field_decoder.sv
// Turns the raddr, waddr and action microcode fields into per-register control bits
`timescale 1ns/1ps

module field_decoder
   import reg_board_pkg::*;
(
   input  field_t     raddr,    // Register that drives the bus
   input  field_t     waddr,    // Register that loads from the bus
   input  field_t     action,   // Inc or dec of one register
   output board_ctl_t ctl       // One control nibble per register
);

   logic r_en;                  // raddr is live
   logic w_en;                  // waddr is live
   logic a_en;                  // action is live

   // Live field means bit 3 high and bit 4 low, like a 138 with G1 and nG2A
   function automatic logic field_live(input field_t f);
      return f[FIELD_EN_BIT] & ~f[FIELD_DIS_BIT];
   endfunction

   assign r_en = field_live(raddr);
   assign w_en = field_live(waddr);
   assign a_en = field_live(action);

   //////////////////////////////
   // Address and action decode
   //////////////////////////////

   always_comb begin
      ctl = '0;                                         // Default is no operation

      // Only 8 to 11 hit a register, 12 to 15 stay idle
      for (int i = 0; i < NUM_REGS; i++) begin
         ctl[i].read  = r_en && (raddr == field_t'(ADDR_REG_BASE + i));   // One-hot by design
         ctl[i].write = w_en && (waddr == field_t'(ADDR_REG_BASE + i));
      end

      if (a_en) begin
         case (action)
            ACT_INC_PC: ctl[REG_PC].inc = 1'b1;         // PC counts up only
            ACT_INC_DR: ctl[REG_DR].inc = 1'b1;
            ACT_DEC_DR: ctl[REG_DR].dec = 1'b1;
            ACT_INC_AC: ctl[REG_AC].inc = 1'b1;
            ACT_DEC_AC: ctl[REG_AC].dec = 1'b1;
            ACT_INC_SP: ctl[REG_SP].inc = 1'b1;
            ACT_DEC_SP: ctl[REG_SP].dec = 1'b1;
            default:    ;                               // Code 9 is free
         endcase
      end
   end

endmodule

// File: src/reg_board_pkg.sv
// Shared types and codes for the register board. Every RTL file and the bench import this package
package reg_board_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int WORD_BITS      = 16;   // Processor word
   localparam int BYTE_BITS      = 8;    // Front panel port width
   localparam int NUM_REGS       = 4;    // PC, DR, AC, SP
   localparam int NUM_FIELD_BITS = 5;    // raddr, waddr and action width
   localparam int PC_OUT_BITS    = 6;    // PC bits given to the backplane

   //////////////////////////////
   // Microcode field codes
   //////////////////////////////

   localparam int FIELD_EN_BIT  = 3;     // Must be 1 for a live field
   localparam int FIELD_DIS_BIT = 4;     // Must be 0 for a live field
   localparam int ADDR_REG_BASE = 8;     // Address of the first register (PC)

   typedef logic [NUM_FIELD_BITS-1:0] field_t;

   // Action codes, 9 is left free
   localparam field_t ACT_INC_PC = 5'd8;
   localparam field_t ACT_INC_DR = 5'd10;
   localparam field_t ACT_DEC_DR = 5'd11;
   localparam field_t ACT_INC_AC = 5'd12;
   localparam field_t ACT_DEC_AC = 5'd13;
   localparam field_t ACT_INC_SP = 5'd14;
   localparam field_t ACT_DEC_SP = 5'd15;

   //////////////////////////////
   // Data and control types
   //////////////////////////////

   typedef logic [WORD_BITS-1:0] word_t;   // Register and bus word

   typedef enum logic [1:0] {
      REG_PC = 2'd0,                       // Program counter
      REG_DR = 2'd1,                       // Data register
      REG_AC = 2'd2,                       // Accumulator
      REG_SP = 2'd3                        // Stack pointer
   } reg_id_t;

   typedef struct packed {
      logic read;                          // Drive the processor bus
      logic write;                         // Load from the processor bus
      logic inc;                           // Add one
      logic dec;                           // Subtract one
   } reg_ctl_t;

   // One control nibble per register, element number is the reg_id_t value
   typedef reg_ctl_t [NUM_REGS-1:0] board_ctl_t;

   typedef struct packed {
      reg_id_t sel_reg;                    // Register shown on the panel
      logic    hi_byte;                    // 1 picks bits 15:8
   } panel_sel_t;

endpackage
